// ==== page_alloc.f ====
verilog/page_alloc_pkg.sv
verilog/page_bitmap.sv
verilog/axil_regs.sv
verilog/page_alloc_top.sv
bench/page_alloc_assert.sv
bench/page_alloc_tb.sv

// ==== Bender.yml ====
package:
  name: page_alloc

sources:
  - verilog/page_alloc_pkg.sv
  - verilog/page_bitmap.sv
  - verilog/axil_regs.sv
  - verilog/page_alloc_top.sv
  - target: test
    files:
      - bench/page_alloc_assert.sv
      - bench/page_alloc_tb.sv

// ==== bench/page_alloc_tb.sv ====
// testbench of the page allocator
// clock, reset and AXI4-Lite master tasks driven on the falling edge
// reference bitmap giving the expected ok, page and free count
// directed and random commands, watchdog and closing summary

`default_nettype none

module page_alloc_tb;

	localparam int PAGES = page_alloc_pkg::MAP_WORDS * page_alloc_pkg::WORD_BITS;
	localparam int HS_LIMIT = 64;
	// planned commands and their worst case latencies in cycles
	localparam int N_CLEAR = 3;
	localparam int N_ALLOC = 15;
	localparam int N_MODIFY = 48 + 128 + 3 + PAGES;
	localparam int CMD_OVERHEAD = 24;
	localparam int RUN_CYCLES = N_CLEAR * 257 + N_ALLOC * 514 + N_MODIFY * 3 +
		(N_CLEAR + N_ALLOC + N_MODIFY + 8) * CMD_OVERHEAD;
	localparam int WATCHDOG_TIME = RUN_CYCLES * 3 / 2 * 20;

	logic        clk = 1'b0;
	logic        rst;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	// a set entry marks a used page, exactly as in the DUT map
	bit model_map [PAGES];
	int model_free;
	int error_count;
	int check_count;
	int seed;

	page_alloc_top uut (
		.clk(clk), .rst(rst),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
		.bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
		.rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
	);

	always #10 clk = ~clk;

	// ====================
	// checks and bus tasks
	// ====================

	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		assert (actual == expected)
		else
		begin
			error_count++;
			$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("failure at %0t: %s", $time, what);
	endtask

	// hold is the number of cycles bready stays low after bvalid rises
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
		int waited;
		resp = 2'b11;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end while (!(awready || wready) && waited < HS_LIMIT);
		if (!(awready || wready))
		begin
			report_failure("write address and data were never accepted");
			awvalid = 1'b0;
			wvalid = 1'b0;
			return;
		end
		// both channels are taken in the same cycle
		check_value("awready", 1, awready);
		check_value("wready", 1, wready);
		// the handshake happens on the rising edge after awready is seen
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (!bvalid)
		begin
			report_failure("no write response after the handshake");
			return;
		end
		repeat (hold) @(negedge clk);
		resp = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, input int hold, output logic [31:0] data,
		output logic [1:0] resp);
		int waited;
		data = '0;
		resp = 2'b11;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
		end while (!arready && waited < HS_LIMIT);
		if (!arready)
		begin
			report_failure("read address was never accepted");
			arvalid = 1'b0;
			return;
		end
		@(negedge clk);
		arvalid = 1'b0;
		if (!rvalid)
		begin
			report_failure("no read response after the handshake");
			return;
		end
		repeat (hold) @(negedge clk);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// software view of a command, poll STATUS until busy clears
	task automatic wait_idle(output logic [31:0] status);
		logic [1:0] resp;
		int polls;
		polls = 0;
		do
		begin
			axil_read(page_alloc_pkg::REG_STATUS, 0, status, resp);
			polls++;
		end while (status[page_alloc_pkg::STAT_BUSY] && polls < 1000);
		if (status[page_alloc_pkg::STAT_BUSY])
			report_failure("engine never left busy");
	endtask

	// ====================
	// reference model
	// ====================

	function automatic int lowest_free();
		for (int p = 0; p < PAGES; p++)
		begin
			if (!model_map[p])
				return p;
		end
		return -1;
	endfunction

	task automatic issue_cmd(input page_alloc_pkg::alloc_op_e op, input int page,
		input logic [1:0] exp_resp, input int hold);
		logic [31:0] data;
		logic [1:0] resp;
		data = '0;
		data[page_alloc_pkg::CMD_OP_HI:page_alloc_pkg::CMD_OP_LO] = op;
		data[page_alloc_pkg::PAGE_HI:page_alloc_pkg::PAGE_LO] =
			page[page_alloc_pkg::PAGE_W-1:0];
		axil_write(page_alloc_pkg::REG_CMD, data, hold, resp);
		check_value("bresp", exp_resp, resp);
	endtask

	// waits for the command to end, then compares it with the model and updates it
	task automatic complete_cmd(input page_alloc_pkg::alloc_op_e op, input int page,
		input bit check_free);
		logic [31:0] status;
		logic [31:0] count;
		logic [1:0] resp;
		int exp_ok;
		int exp_page;
		wait_idle(status);
		exp_ok = 0;
		exp_page = page;
		case (op)
		page_alloc_pkg::OP_ALLOC:
		begin
			exp_page = lowest_free();
			exp_ok = (exp_page >= 0);
			if (exp_ok)
			begin
				model_map[exp_page] = 1'b1;
				model_free--;
			end
			else
				exp_page = 0;
		end
		page_alloc_pkg::OP_RESERVE:
		begin
			// ok only if the page was free before
			exp_ok = !model_map[page];
			model_map[page] = 1'b1;
			model_free -= exp_ok;
		end
		page_alloc_pkg::OP_FREE:
		begin
			exp_ok = model_map[page];
			model_map[page] = 1'b0;
			model_free += exp_ok;
		end
		default:
		begin
			foreach (model_map[p])
				model_map[p] = 1'b0;
			model_free = PAGES;
			exp_ok = 1;
			exp_page = 0;
		end
		endcase
		check_value("status.ok", exp_ok, status[page_alloc_pkg::STAT_OK]);
		check_value("status.page", exp_page,
			status[page_alloc_pkg::PAGE_HI:page_alloc_pkg::PAGE_LO]);
		if (check_free)
		begin
			axil_read(page_alloc_pkg::REG_FREE, 0, count, resp);
			check_value("rresp", page_alloc_pkg::RESP_OKAY, resp);
			check_value("free_count", model_free, count);
		end
	endtask

	task automatic exec_cmd(input page_alloc_pkg::alloc_op_e op, input int page,
		input bit check_free);
		issue_cmd(op, page, page_alloc_pkg::RESP_OKAY, 0);
		complete_cmd(op, page, check_free);
	endtask

	// ====================
	// stimulus
	// ====================

	initial
	begin
		logic [31:0] data;
		logic [1:0] resp;
		int page;
		seed = 66;
		error_count = 0;
		check_count = 0;
		model_free = PAGES;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset runs a clear, afterwards pages come out in order
		complete_cmd(page_alloc_pkg::OP_CLEAR, 0, 1);
		for (int i = 0; i < 8; i++)
			exec_cmd(page_alloc_pkg::OP_ALLOC, 0, 1);

		// random reserve and free over the first four words
		for (int i = 0; i < 48; i++)
		begin
			page = $random(seed) & 255;
			if ($random(seed) & 1)
				exec_cmd(page_alloc_pkg::OP_RESERVE, page, 1);
			else
				exec_cmd(page_alloc_pkg::OP_FREE, page, 1);
		end
		for (int i = 0; i < 4; i++)
			exec_cmd(page_alloc_pkg::OP_ALLOC, 0, 1);

		// words 0 and 1 full, so the search has to move into word 2 or later
		for (int p = 0; p < 128; p++)
		begin
			if (!model_map[p])
				exec_cmd(page_alloc_pkg::OP_RESERVE, p, 0);
		end
		exec_cmd(page_alloc_pkg::OP_ALLOC, 0, 1);

		// second reserve of a used page and free of a free page both fail
		exec_cmd(page_alloc_pkg::OP_RESERVE, 5, 1);
		exec_cmd(page_alloc_pkg::OP_FREE, lowest_free(), 1);

		// a command during a clear is refused and leaves no trace
		issue_cmd(page_alloc_pkg::OP_CLEAR, 0, page_alloc_pkg::RESP_OKAY, 0);
		issue_cmd(page_alloc_pkg::OP_ALLOC, 0, page_alloc_pkg::RESP_SLVERR, 0);
		complete_cmd(page_alloc_pkg::OP_CLEAR, 0, 1);
		issue_cmd(page_alloc_pkg::OP_NOP, 0, page_alloc_pkg::RESP_OKAY, 0);
		axil_write(page_alloc_pkg::REG_STATUS, 32'h1, 0, resp);
		check_value("bresp", page_alloc_pkg::RESP_SLVERR, resp);
		axil_write(4'hc, 32'h1, 0, resp);
		check_value("bresp", page_alloc_pkg::RESP_SLVERR, resp);
		axil_read(4'hc, 0, data, resp);
		check_value("rresp", page_alloc_pkg::RESP_SLVERR, resp);
		exec_cmd(page_alloc_pkg::OP_ALLOC, 0, 1);

		// fill the whole map, then ALLOC must fail with page 0
		exec_cmd(page_alloc_pkg::OP_CLEAR, 0, 1);
		for (int p = 0; p < PAGES; p++)
		begin
			if (!model_map[p])
				exec_cmd(page_alloc_pkg::OP_RESERVE, p, 0);
		end
		exec_cmd(page_alloc_pkg::OP_ALLOC, 0, 1);

		// responses held by a slow master
		issue_cmd(page_alloc_pkg::OP_FREE, 77, page_alloc_pkg::RESP_OKAY, 6);
		complete_cmd(page_alloc_pkg::OP_FREE, 77, 0);
		axil_read(page_alloc_pkg::REG_FREE, 6, data, resp);
		check_value("free_count", model_free, data);

		$display("summary: %0d checks, %0d errors, %0d protocol assertion failures",
			check_count, error_count, uut.u_regs.u_assert.fail_count);
		if (error_count == 0 && uut.u_regs.u_assert.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_TIME);
		$display("timeout: commands still running after %0d cycles", RUN_CYCLES * 3 / 2);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/page_alloc_assert.sv ====
// protocol assertions of the AXI4-Lite front end
// held write and read responses, legal response codes
// single cycle engine request that only starts an idle engine
// bound into every axil_regs instance

`default_nettype none

module page_alloc_assert (
	input logic                       clk,
	input logic                       rst,
	input logic                       bvalid_i,
	input logic                       bready_i,
	input logic [1:0]                 bresp_i,
	input logic                       rvalid_i,
	input logic                       rready_i,
	input logic [1:0]                 rresp_i,
	input logic [31:0]                rdata_i,
	input page_alloc_pkg::alloc_req_t req_i,
	input logic                       busy_i
);

	// number of assertion failures so far
	int fail_count = 0;

	// a response stays valid and unchanged until the master takes it
	assert property (@(posedge clk) disable iff (rst)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
	else
	begin
		$error("write response dropped or changed while bready was low");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (rst)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
	else
	begin
		$error("read response dropped or changed while rready was low");
		fail_count++;
	end

	// the request is a pulse and reaches an idle engine
	assert property (@(posedge clk) disable iff (rst) req_i.valid |=> !req_i.valid)
	else
	begin
		$error("engine request lasted two cycles");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (rst) req_i.valid |-> !busy_i)
	else
	begin
		$error("engine request issued while the engine was busy");
		fail_count++;
	end

	// only OKAY and SLVERR are ever returned
	assert property (@(posedge clk) disable iff (rst)
		(!bvalid_i || (bresp_i inside {2'b00, 2'b10})) &&
		(!rvalid_i || (rresp_i inside {2'b00, 2'b10})))
	else
	begin
		$error("response code other than OKAY or SLVERR");
		fail_count++;
	end

endmodule

bind axil_regs page_alloc_assert u_assert (
	.clk(clk), .rst(rst),
	.bvalid_i(bvalid_o), .bready_i(bready_i), .bresp_i(bresp_o),
	.rvalid_i(rvalid_o), .rready_i(rready_i), .rresp_i(rresp_o), .rdata_i(rdata_o),
	.req_i(req_o), .busy_i(busy_i)
);

`default_nettype wire

// ==== verilog/page_alloc_top.sv ====
// page allocator top level
// AXI4-Lite register front end driving the bitmap engine

`default_nettype none

module page_alloc_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [page_alloc_pkg::AXI_ADDR_W-1:0] awaddr_i,
	input  logic                                  awvalid_i,
	output logic                                  awready_o,
	input  logic [page_alloc_pkg::AXI_DATA_W-1:0] wdata_i,
	input  logic [3:0]                            wstrb_i,
	input  logic                                  wvalid_i,
	output logic                                  wready_o,
	output logic [1:0]                            bresp_o,
	output logic                                  bvalid_o,
	input  logic                                  bready_i,
	input  logic [page_alloc_pkg::AXI_ADDR_W-1:0] araddr_i,
	input  logic                                  arvalid_i,
	output logic                                  arready_o,
	output logic [page_alloc_pkg::AXI_DATA_W-1:0] rdata_o,
	output logic [1:0]                            rresp_o,
	output logic                                  rvalid_o,
	input  logic                                  rready_i
);

	// command path into the engine and status path back out
	page_alloc_pkg::alloc_req_t         req;
	logic                               busy;
	page_alloc_pkg::alloc_rsp_t         rsp;
	logic [page_alloc_pkg::COUNT_W-1:0] free_count;

	axil_regs u_regs (
		.clk(clk), .rst(rst),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
		.req_o(req), .busy_i(busy), .rsp_i(rsp), .free_count_i(free_count)
	);

	page_bitmap u_bitmap (
		.clk(clk),
		.rst(rst),
		.req_i(req),
		.busy_o(busy),
		.rsp_o(rsp),
		.free_count_o(free_count)
	);

endmodule

`default_nettype wire

// ==== verilog/axil_regs.sv ====
// AXI4-Lite register front end of the page allocator
// write channel with CMD decode and the one cycle engine request
// read channel for STATUS and FREE
// SLVERR for unmapped offsets, read-only targets and commands while busy

`default_nettype none

module axil_regs (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [page_alloc_pkg::AXI_ADDR_W-1:0] awaddr_i,
	input  logic                                  awvalid_i,
	output logic                                  awready_o,
	input  logic [page_alloc_pkg::AXI_DATA_W-1:0] wdata_i,
	input  logic [3:0]                            wstrb_i,
	input  logic                                  wvalid_i,
	output logic                                  wready_o,
	output logic [1:0]                            bresp_o,
	output logic                                  bvalid_o,
	input  logic                                  bready_i,
	input  logic [page_alloc_pkg::AXI_ADDR_W-1:0] araddr_i,
	input  logic                                  arvalid_i,
	output logic                                  arready_o,
	output logic [page_alloc_pkg::AXI_DATA_W-1:0] rdata_o,
	output logic [1:0]                            rresp_o,
	output logic                                  rvalid_o,
	input  logic                                  rready_i,
	output page_alloc_pkg::alloc_req_t            req_o,
	input  logic                                  busy_i,
	input  page_alloc_pkg::alloc_rsp_t            rsp_i,
	input  logic [page_alloc_pkg::COUNT_W-1:0]    free_count_i
);

	logic                                  awready_q;
	logic                                  bvalid_q;
	logic [1:0]                            bresp_q;
	logic                                  wr_hs;
	logic                                  cmd_busy;
	page_alloc_pkg::alloc_op_e             wr_op;
	logic                                  wr_go;
	logic [1:0]                            wr_resp;
	page_alloc_pkg::alloc_req_t            req_q;
	logic                                  arready_q;
	logic                                  rvalid_q;
	logic [1:0]                            rresp_q;
	logic [page_alloc_pkg::AXI_DATA_W-1:0] rdata_q;
	logic                                  rd_hs;
	logic [1:0]                            rd_resp;
	logic [page_alloc_pkg::AXI_DATA_W-1:0] rd_data;

	// ====================
	// write channel
	// ====================

	// the handshake completes in the cycle where the registered ready is high
	assign wr_hs = awready_q & awvalid_i & wvalid_i;
	// a request in flight counts as busy until the engine raises busy itself
	assign cmd_busy = busy_i | req_q.valid;
	assign wr_op = page_alloc_pkg::alloc_op_e'(wdata_i[page_alloc_pkg::CMD_OP_HI:
		page_alloc_pkg::CMD_OP_LO]);

	// only CMD is writable and every write takes the full word, so wstrb_i
	// has no effect on the result
	always_comb
	begin
		wr_go = 1'b0;
		wr_resp = page_alloc_pkg::RESP_SLVERR;
		if (awaddr_i == page_alloc_pkg::REG_CMD)
		begin
			if (cmd_busy)
				wr_resp = page_alloc_pkg::RESP_SLVERR;
			else if (wr_op == page_alloc_pkg::OP_NOP)
				wr_resp = page_alloc_pkg::RESP_OKAY;
			else if (wr_op == page_alloc_pkg::OP_ALLOC || wr_op == page_alloc_pkg::OP_RESERVE ||
				wr_op == page_alloc_pkg::OP_FREE || wr_op == page_alloc_pkg::OP_CLEAR)
			begin
				wr_go = 1'b1;
				wr_resp = page_alloc_pkg::RESP_OKAY;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			awready_q <= 1'b0;
			bvalid_q <= 1'b0;
			req_q.valid <= 1'b0;
		end
		else
		begin
			// address and data are taken together, never while a response waits
			awready_q <= awvalid_i & wvalid_i & ~bvalid_q & ~awready_q;
			if (wr_hs)
			begin
				bvalid_q <= 1'b1;
				bresp_q <= wr_resp;
			end
			else if (bvalid_q && bready_i)
			begin
				bvalid_q <= 1'b0;
			end
			// the request lives for exactly the cycle after the handshake
			req_q.valid <= wr_hs & wr_go;
			if (wr_hs && wr_go)
			begin
				req_q.op <= wr_op;
				req_q.page <= wdata_i[page_alloc_pkg::PAGE_HI:page_alloc_pkg::PAGE_LO];
			end
		end
	end

	// ====================
	// read channel
	// ====================

	assign rd_hs = arready_q & arvalid_i;

	// CMD reads back as zero, it holds nothing worth reporting
	always_comb
	begin
		rd_data = '0;
		rd_resp = page_alloc_pkg::RESP_OKAY;
		case (araddr_i)
		page_alloc_pkg::REG_CMD:
		begin
			rd_data = '0;
		end
		page_alloc_pkg::REG_STATUS:
		begin
			rd_data[page_alloc_pkg::STAT_BUSY] = cmd_busy;
			rd_data[page_alloc_pkg::STAT_OK] = rsp_i.ok;
			rd_data[page_alloc_pkg::PAGE_HI:page_alloc_pkg::PAGE_LO] = rsp_i.page;
		end
		page_alloc_pkg::REG_FREE:
		begin
			rd_data[page_alloc_pkg::COUNT_W-1:0] = free_count_i;
		end
		default:
		begin
			rd_resp = page_alloc_pkg::RESP_SLVERR;
		end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
		end
		else
		begin
			arready_q <= arvalid_i & ~rvalid_q & ~arready_q;
			if (rd_hs)
			begin
				// data is sampled at the handshake and held until rready
				rvalid_q <= 1'b1;
				rdata_q <= rd_data;
				rresp_q <= rd_resp;
			end
			else if (rvalid_q && rready_i)
			begin
				rvalid_q <= 1'b0;
			end
		end
	end

	assign awready_o = awready_q;
	assign wready_o = awready_q;
	assign bvalid_o = bvalid_q;
	assign bresp_o = bresp_q;
	assign arready_o = arready_q;
	assign rvalid_o = rvalid_q;
	assign rdata_o = rdata_q;
	assign rresp_o = rresp_q;
	assign req_o = req_q;

endmodule

`default_nettype wire

// ==== verilog/page_bitmap.sv ====
// page bitmap engine
// map storage with one synchronous read port and one write port
// command FSM for ALLOC, RESERVE, FREE and CLEAR
// lowest zero priority search over the fetched word
// free page counter and the response of the last command

`default_nettype none

module page_bitmap (
	input  logic                               clk,
	input  logic                               rst,
	input  page_alloc_pkg::alloc_req_t         req_i,
	output logic                               busy_o,
	output page_alloc_pkg::alloc_rsp_t         rsp_o,
	output logic [page_alloc_pkg::COUNT_W-1:0] free_count_o
);

	// a set bit in the map marks a used page
	logic [page_alloc_pkg::WORD_BITS-1:0] map_mem [page_alloc_pkg::MAP_WORDS];
	logic [page_alloc_pkg::WORD_BITS-1:0] rd_word;
	logic [page_alloc_pkg::WORD_W-1:0]    rd_addr;
	logic                                 wr_en;
	logic [page_alloc_pkg::WORD_BITS-1:0] wr_data;

	page_alloc_pkg::bitmap_state_e        state_q;
	page_alloc_pkg::alloc_op_e            op_q;
	logic [page_alloc_pkg::WORD_W-1:0]    word_q;
	logic [page_alloc_pkg::BIT_W-1:0]     bit_q;
	logic                                 hit_q;
	logic [page_alloc_pkg::WORD_BITS-1:0] new_word_q;
	logic [page_alloc_pkg::WORD_BITS-1:0] bit_mask;
	logic                                 free_found;
	logic [page_alloc_pkg::BIT_W-1:0]     free_bit;
	page_alloc_pkg::alloc_rsp_t           rsp_q;
	logic [page_alloc_pkg::COUNT_W-1:0]   free_q;

	// ====================
	// map storage
	// ====================

	// the write address is always the current word index
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			map_mem[word_q] <= wr_data;
		end
		rd_word <= map_mem[rd_addr];
	end

	// while idle the read port looks at the word of the incoming request,
	// so RESERVE and FREE find their data ready in the next cycle
	always_comb
	begin
		if (state_q == page_alloc_pkg::ST_IDLE)
		begin
			if (req_i.op == page_alloc_pkg::OP_ALLOC)
				rd_addr = '0;
			else
				rd_addr = req_i.page[page_alloc_pkg::PAGE_W-1:page_alloc_pkg::BIT_W];
		end
		else
		begin
			rd_addr = word_q;
		end
	end

	// clearing writes zeros, a command writes back only when it changed a bit
	assign wr_en = (state_q == page_alloc_pkg::ST_CLEAR) ||
		((state_q == page_alloc_pkg::ST_WRITE) && hit_q);
	assign wr_data = (state_q == page_alloc_pkg::ST_CLEAR) ? '0 : new_word_q;

	// ====================
	// search and modify
	// ====================

	// scanning from the top down leaves the lowest zero bit as the result
	always_comb
	begin
		free_found = ~&rd_word;
		free_bit = '0;
		for (int i = page_alloc_pkg::WORD_BITS - 1; i >= 0; i--)
		begin
			if (!rd_word[i])
				free_bit = i[page_alloc_pkg::BIT_W-1:0];
		end
	end

	always_comb
	begin
		bit_mask = '0;
		bit_mask[bit_q] = 1'b1;
	end

	// ====================
	// command FSM
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// reset starts a full clear of the map
			state_q <= page_alloc_pkg::ST_CLEAR;
			word_q <= '0;
			hit_q <= 1'b0;
			free_q <= '0;
			rsp_q <= '0;
		end
		else
		begin
			case (state_q)
			page_alloc_pkg::ST_IDLE:
			begin
				if (req_i.valid)
				begin
					op_q <= req_i.op;
					word_q <= req_i.page[page_alloc_pkg::PAGE_W-1:page_alloc_pkg::BIT_W];
					bit_q <= req_i.page[page_alloc_pkg::BIT_W-1:0];
					case (req_i.op)
					page_alloc_pkg::OP_ALLOC:
					begin
						// word 0 is already being read this cycle
						word_q <= '0;
						state_q <= page_alloc_pkg::ST_SCAN;
					end
					page_alloc_pkg::OP_RESERVE, page_alloc_pkg::OP_FREE:
					begin
						state_q <= page_alloc_pkg::ST_MODIFY;
					end
					page_alloc_pkg::OP_CLEAR:
					begin
						word_q <= '0;
						state_q <= page_alloc_pkg::ST_CLEAR;
					end
					default:
					begin
						state_q <= page_alloc_pkg::ST_IDLE;
					end
					endcase
				end
			end
			page_alloc_pkg::ST_CLEAR:
			begin
				// one word per cycle, the whole map is free when the last lands
				word_q <= word_q + 1'b1;
				if (word_q == page_alloc_pkg::MAP_WORDS - 1)
				begin
					free_q <= page_alloc_pkg::FREE_ALL;
					rsp_q.ok <= 1'b1;
					rsp_q.page <= '0;
					state_q <= page_alloc_pkg::ST_IDLE;
				end
			end
			page_alloc_pkg::ST_READ:
			begin
				state_q <= page_alloc_pkg::ST_SCAN;
			end
			page_alloc_pkg::ST_SCAN:
			begin
				if (free_found)
				begin
					bit_q <= free_bit;
					state_q <= page_alloc_pkg::ST_MODIFY;
				end
				else if (word_q == page_alloc_pkg::MAP_WORDS - 1)
				begin
					// every word was full so the map has no free page
					rsp_q.ok <= 1'b0;
					rsp_q.page <= '0;
					state_q <= page_alloc_pkg::ST_IDLE;
				end
				else
				begin
					word_q <= word_q + 1'b1;
					state_q <= page_alloc_pkg::ST_READ;
				end
			end
			page_alloc_pkg::ST_MODIFY:
			begin
				// FREE needs the bit set, ALLOC and RESERVE need it clear
				hit_q <= (rd_word[bit_q] == (op_q == page_alloc_pkg::OP_FREE));
				new_word_q <= rd_word ^ bit_mask;
				state_q <= page_alloc_pkg::ST_WRITE;
			end
			page_alloc_pkg::ST_WRITE:
			begin
				rsp_q.ok <= hit_q;
				rsp_q.page <= {word_q, bit_q};
				if (hit_q)
				begin
					if (op_q == page_alloc_pkg::OP_FREE)
						free_q <= free_q + 1'b1;
					else
						free_q <= free_q - 1'b1;
				end
				state_q <= page_alloc_pkg::ST_IDLE;
			end
			default:
			begin
				state_q <= page_alloc_pkg::ST_IDLE;
			end
			endcase
		end
	end

	assign busy_o = (state_q != page_alloc_pkg::ST_IDLE);
	assign rsp_o = rsp_q;
	assign free_count_o = free_q;

endmodule

`default_nettype wire

// ==== verilog/page_alloc_pkg.sv ====
// shared definitions of the page allocator
// map geometry, page number and free count widths
// command opcodes and bitmap engine states
// request and response structs between front end and engine
// AXI4-Lite register offsets, response codes and field positions

`default_nettype none

package page_alloc_pkg;

	// ====================
	// map geometry
	// ====================

	// one map word carries the used flags of 64 consecutive pages
	localparam int MAP_WORDS = 256;
	localparam int WORD_BITS = 64;
	localparam int WORD_W = 8;
	localparam int BIT_W = 6;
	// a page number is the word index on top of the bit index
	localparam int PAGE_W = WORD_W + BIT_W;
	// one bit wider than a page number so that an empty map fits
	localparam int COUNT_W = PAGE_W + 1;
	localparam logic [COUNT_W-1:0] FREE_ALL = COUNT_W'(MAP_WORDS * WORD_BITS);

	// commands as they appear in CMD bits 2:0
	typedef enum logic [2:0] {
		OP_NOP     = 3'd0,
		OP_ALLOC   = 3'd1,
		OP_RESERVE = 3'd2,
		OP_FREE    = 3'd3,
		OP_CLEAR   = 3'd4
	} alloc_op_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_READ,
		ST_SCAN,
		ST_MODIFY,
		ST_WRITE
	} bitmap_state_e;

	// valid is a single cycle pulse, page is ignored by ALLOC and CLEAR
	typedef struct packed {
		logic              valid;
		alloc_op_e         op;
		logic [PAGE_W-1:0] page;
	} alloc_req_t;

	typedef struct packed {
		logic              ok;
		logic [PAGE_W-1:0] page;
	} alloc_rsp_t;

	// ====================
	// register map
	// ====================

	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;
	localparam logic [AXI_ADDR_W-1:0] REG_CMD = 4'h0;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h4;
	localparam logic [AXI_ADDR_W-1:0] REG_FREE = 4'h8;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// the page field sits at the same place in CMD and STATUS
	localparam int CMD_OP_LO = 0;
	localparam int CMD_OP_HI = 2;
	localparam int PAGE_LO = 16;
	localparam int PAGE_HI = PAGE_LO + PAGE_W - 1;
	localparam int STAT_BUSY = 0;
	localparam int STAT_OK = 1;

endpackage

`default_nettype wire
